// ==== design/divsqrt_pkg.sv ====
// ------------------------------------------------
// Shared widths, operation codes and iteration counts
// for the integer divide and square-root unit
// ------------------------------------------------

`default_nettype none

package divsqrt_pkg;

  // ------------------------------------------------
  // Datapath widths
  // ------------------------------------------------
  // Operand, quotient, root and remainder width
  localparam int unsigned DATA_W = 16;
  // Tag carried alongside every operation
  localparam int unsigned TAG_W = 4;

  // ------------------------------------------------
  // Operation encoding
  // ------------------------------------------------
  // Unsigned divide giving quotient and remainder
  localparam logic OP_DIV = 1'b0;
  // Integer square root giving root and remainder
  localparam logic OP_SQRT = 1'b1;

  // ------------------------------------------------
  // Iteration counts
  // ------------------------------------------------
  // One quotient bit per cycle
  localparam int unsigned DIV_ITERS = 16;
  // One root bit per cycle, two radicand bits consumed each time
  localparam int unsigned SQRT_ITERS = 8;
  // Counter must hold DIV_ITERS itself
  localparam int unsigned CNT_W = 5;

  // ------------------------------------------------
  // Stage payloads
  // ------------------------------------------------
  // Input side packs opa, opb, op and tag
  localparam int unsigned IN_PAYLOAD_W = 2 * DATA_W + 1 + TAG_W;
  // Output side packs result, remainder, dz flag and tag
  localparam int unsigned OUT_PAYLOAD_W = 2 * DATA_W + 1 + TAG_W;

endpackage

`default_nettype wire

// ==== design/divsqrt_pipe_reg.sv ====
// ------------------------------------------------
// Single elastic valid/ready register slice with flush
// Used on both the input and the output side of the unit
// ------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module divsqrt_pipe_reg #(
  parameter int unsigned PAYLOAD_W = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Synchronous clear of the stage contents
  input  logic                 flush_i,
  // Upstream side
  input  logic                 valid_i,
  input  logic [PAYLOAD_W-1:0] data_i,
  output logic                 ready_o,
  // Downstream side
  output logic                 valid_o,
  output logic [PAYLOAD_W-1:0] data_o,
  input  logic                 ready_i
);

  logic                 valid_q;
  logic [PAYLOAD_W-1:0] data_q;
  logic                 load_en;

  // ------------------------------------------------
  // Handshake
  // ------------------------------------------------
  // Advance when downstream takes our item or when we only hold a bubble
  assign ready_o = ready_i | ~valid_q;

  // Data moves only on a real transfer into the slice
  assign load_en = valid_i & ready_o;

  // Valid flag, flush beats a load
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // ------------------------------------------------
  // Payload
  // ------------------------------------------------
  // Cleared on reset so that outputs start at a known zero
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      data_q <= '0;
    end else if (load_en) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

`default_nettype wire

// ==== design/divsqrt_ctrl.sv ====
// ------------------------------------------------
// IDLE/BUSY/HOLD control FSM around the iterative core
// Starts operations, keeps the tag, offers results downstream
// ------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module divsqrt_ctrl
  import divsqrt_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             flush_i,
  // From the input stage
  input  logic             in_valid_i,
  input  logic [TAG_W-1:0] tag_i,
  output logic             in_ready_o,
  // Core interface
  output logic             unit_start_o,
  input  logic             unit_done_i,
  // Toward the output stage
  output logic             out_valid_o,
  output logic [TAG_W-1:0] tag_o,
  input  logic             out_ready_i,
  // Operation in flight
  output logic             busy_o
);

  // FSM encodings
  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_BUSY = 2'd1;
  localparam logic [1:0] ST_HOLD = 2'd2;

  logic [1:0]       state_q;
  logic [1:0]       state_d;
  logic [TAG_W-1:0] tag_q;

  // A new operation starts whenever the input item is acknowledged
  assign unit_start_o = in_valid_i & in_ready_o & ~flush_i;

  // ------------------------------------------------
  // Next state and handshake outputs
  // ------------------------------------------------
  always_comb begin
    in_ready_o  = 1'b0;
    out_valid_o = 1'b0;
    busy_o      = 1'b0;
    state_d     = state_q;
    case (state_q)
      // Waiting for work, unit is free
      ST_IDLE: begin
        in_ready_o = 1'b1;
        if (in_valid_i) begin
          state_d = ST_BUSY;
        end
      end
      // Core iterating
      ST_BUSY: begin
        busy_o = 1'b1;
        if (unit_done_i) begin
          out_valid_o = 1'b1;
          if (out_ready_i) begin
            // Result taken, next item may start in the same cycle
            in_ready_o = 1'b1;
            state_d    = in_valid_i ? ST_BUSY : ST_IDLE;
          end else begin
            state_d = ST_HOLD;
          end
        end
      end
      // Result waiting on back-pressure, core outputs stay put
      ST_HOLD: begin
        busy_o      = 1'b1;
        out_valid_o = 1'b1;
        if (out_ready_i) begin
          in_ready_o = 1'b1;
          state_d    = in_valid_i ? ST_BUSY : ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
    // Flush drops everything in flight
    if (flush_i) begin
      out_valid_o = 1'b0;
      busy_o      = 1'b0;
      state_d     = ST_IDLE;
    end
  end

  // State register
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Tag follows the operation from start to result
  always_ff @(posedge clk_i) begin
    if (unit_start_o) begin
      tag_q <= tag_i;
    end
  end

  assign tag_o = tag_q;

endmodule

`default_nettype wire

// ==== design/divsqrt_iter_unit.sv ====
// ------------------------------------------------
// Iterative core, restoring divide at one bit per cycle
// and digit-by-digit square root at one root bit per cycle
// ------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module divsqrt_iter_unit
  import divsqrt_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Abort the running operation
  input  logic              kill_i,
  input  logic              start_i,
  input  logic              op_i,
  input  logic [DATA_W-1:0] opa_i,
  input  logic [DATA_W-1:0] opb_i,
  // One-cycle completion pulse
  output logic              done_o,
  output logic [DATA_W-1:0] result_o,
  output logic [DATA_W-1:0] rem_o,
  output logic              dz_o
);

  // Control state
  logic             run_q;
  logic [CNT_W-1:0] cnt_q;
  logic             dz_q;
  // Datapath registers
  logic                  op_q;
  logic [DATA_W-1:0]     quot_q;   // dividend or radicand shifting out, quotient in
  logic [DATA_W-1:0]     rem_q;    // partial remainder for both operations
  logic [DATA_W-1:0]     div_q;    // divisor
  logic [DATA_W/2-1:0]   root_q;
  logic                  start_dz;
  logic                  iter_en;
  // Divide step
  logic [DATA_W:0]       d_shift;
  logic [DATA_W:0]       d_diff;
  logic                  d_ge;
  // Root step
  logic [DATA_W+1:0]     s_shift;
  logic [DATA_W+1:0]     s_trial;
  logic [DATA_W+1:0]     s_diff;
  logic                  s_ge;

  // Zero divisor spotted when the operation is launched
  assign start_dz = (op_i == OP_DIV) && (opb_i == '0);
  // Iterate while counting down, frozen result for divide by zero
  assign iter_en  = run_q & (cnt_q != '0) & ~dz_q;
  // Finished once the counter has run out
  assign done_o   = run_q & (cnt_q == '0);

  // ------------------------------------------------
  // Step arithmetic
  // ------------------------------------------------
  // Bring down the next dividend bit and trial subtract
  assign d_shift = {rem_q, quot_q[DATA_W-1]};
  assign d_diff  = d_shift - {1'b0, div_q};
  assign d_ge    = d_shift >= {1'b0, div_q};

  // Bring down two radicand bits, trial value is 4*root+1
  assign s_shift = {rem_q, quot_q[DATA_W-1 -: 2]};
  assign s_trial = {{(DATA_W/2){1'b0}}, root_q, 2'b01};
  assign s_diff  = s_shift - s_trial;
  assign s_ge    = s_shift >= s_trial;

  // ------------------------------------------------
  // Sequencing
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      run_q <= 1'b0;
      cnt_q <= '0;
      dz_q  <= 1'b0;
    end else if (kill_i) begin
      run_q <= 1'b0;
    end else if (start_i) begin
      run_q <= 1'b1;
      cnt_q <= (op_i == OP_SQRT) ? CNT_W'(SQRT_ITERS) : CNT_W'(DIV_ITERS);
      dz_q  <= start_dz;
    end else if (done_o) begin
      run_q <= 1'b0;
    end else if (run_q) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // ------------------------------------------------
  // Datapath
  // ------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      op_q   <= op_i;
      div_q  <= opb_i;
      root_q <= '0;
      // Divide by zero forces all ones with the dividend left over
      quot_q <= start_dz ? '1 : opa_i;
      rem_q  <= start_dz ? opa_i : '0;
    end else if (iter_en) begin
      if (op_q == OP_DIV) begin
        quot_q <= {quot_q[DATA_W-2:0], d_ge};
        rem_q  <= d_ge ? d_diff[DATA_W-1:0] : d_shift[DATA_W-1:0];
      end else begin
        quot_q <= {quot_q[DATA_W-3:0], 2'b00};
        root_q <= {root_q[DATA_W/2-2:0], s_ge};
        rem_q  <= s_ge ? s_diff[DATA_W-1:0] : s_shift[DATA_W-1:0];
      end
    end
  end

  // Root is zero extended to the full result width
  assign result_o = (op_q == OP_SQRT) ? {{(DATA_W/2){1'b0}}, root_q} : quot_q;
  assign rem_o    = rem_q;
  assign dz_o     = dz_q;

endmodule

`default_nettype wire

// ==== design/divsqrt_top.sv ====
// ------------------------------------------------
// Top level of the divide/square-root unit
// Input slice, control FSM with core, then output slice
// ------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module divsqrt_top
  import divsqrt_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Upstream handshake and operands
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  logic [DATA_W-1:0] opa_i,
  input  logic [DATA_W-1:0] opb_i,
  input  logic              op_i,
  input  logic [TAG_W-1:0]  tag_i,
  input  logic              flush_i,
  // Downstream handshake and results
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output logic [DATA_W-1:0] result_o,
  output logic [DATA_W-1:0] rem_o,
  output logic              dz_o,
  output logic [TAG_W-1:0]  tag_o,
  // Anything in flight
  output logic              busy_o
);

  // Input slice
  logic                     in_valid_q;
  logic [IN_PAYLOAD_W-1:0]  in_data_q;
  logic                     ctrl_in_ready;
  // Unpacked input item
  logic [DATA_W-1:0]        opa_q;
  logic [DATA_W-1:0]        opb_q;
  logic                     op_q;
  logic [TAG_W-1:0]         tag_q;
  // Core and control
  logic                     unit_start;
  logic                     unit_done;
  logic [DATA_W-1:0]        unit_result;
  logic [DATA_W-1:0]        unit_rem;
  logic                     unit_dz;
  logic                     ctrl_out_valid;
  logic [TAG_W-1:0]         ctrl_tag;
  logic                     ctrl_busy;
  // Output slice
  logic                     out_stage_ready;
  logic                     out_valid_q;
  logic [OUT_PAYLOAD_W-1:0] out_data_q;

  // ------------------------------------------------
  // Input side
  // ------------------------------------------------
  divsqrt_pipe_reg #(
    .PAYLOAD_W (IN_PAYLOAD_W)
  ) u_in_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (in_valid_i),
    .data_i  ({opa_i, opb_i, op_i, tag_i}),
    .ready_o (in_ready_o),
    .valid_o (in_valid_q),
    .data_o  (in_data_q),
    .ready_i (ctrl_in_ready)
  );

  assign {opa_q, opb_q, op_q, tag_q} = in_data_q;

  // ------------------------------------------------
  // Processing
  // ------------------------------------------------
  divsqrt_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .in_valid_i   (in_valid_q),
    .tag_i        (tag_q),
    .in_ready_o   (ctrl_in_ready),
    .unit_start_o (unit_start),
    .unit_done_i  (unit_done),
    .out_valid_o  (ctrl_out_valid),
    .tag_o        (ctrl_tag),
    .out_ready_i  (out_stage_ready),
    .busy_o       (ctrl_busy)
  );

  // Operands go straight from the input slice to the core
  divsqrt_iter_unit u_unit (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .kill_i   (flush_i),
    .start_i  (unit_start),
    .op_i     (op_q),
    .opa_i    (opa_q),
    .opb_i    (opb_q),
    .done_o   (unit_done),
    .result_o (unit_result),
    .rem_o    (unit_rem),
    .dz_o     (unit_dz)
  );

  // ------------------------------------------------
  // Output side
  // ------------------------------------------------
  divsqrt_pipe_reg #(
    .PAYLOAD_W (OUT_PAYLOAD_W)
  ) u_out_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (ctrl_out_valid),
    .data_i  ({unit_result, unit_rem, unit_dz, ctrl_tag}),
    .ready_o (out_stage_ready),
    .valid_o (out_valid_q),
    .data_o  (out_data_q),
    .ready_i (out_ready_i)
  );

  assign {result_o, rem_o, dz_o, tag_o} = out_data_q;
  assign out_valid_o = out_valid_q;

  // Busy covers both slices and the core
  assign busy_o = in_valid_q | ctrl_busy | out_valid_q;

endmodule

`default_nettype wire

// ==== sim/divsqrt_chk.sv ====
// ------------------------------------------------
// Handshake and flush assertions, bound to the top level
// ------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module divsqrt_chk
  import divsqrt_pkg::*;
(
  input logic              clk_i,
  input logic              rst_n_i,
  input logic              flush_i,
  input logic              out_valid_i,
  input logic              out_ready_i,
  input logic [DATA_W-1:0] result_i,
  input logic [DATA_W-1:0] rem_i,
  input logic              dz_i,
  input logic [TAG_W-1:0]  tag_i,
  input logic              busy_i
);

  logic [OUT_PAYLOAD_W-1:0] payload;

  assign payload = {result_i, rem_i, dz_i, tag_i};

  // Stalled result keeps valid and data steady
  stall_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i && !out_ready_i && !flush_i |=> out_valid_i && $stable(payload))
    else $error("output changed while stalled");

  // Flush empties the output slice
  flush_clear_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !out_valid_i)
    else $error("out_valid_o high after flush");

  // A new result only appears after the unit was seen busy
  busy_cover_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(out_valid_i) |-> $past(busy_i))
    else $error("out_valid_o rose without busy_o in the cycle before");

endmodule

bind divsqrt_top divsqrt_chk u_chk (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .flush_i     (flush_i),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i),
  .result_i    (result_o),
  .rem_i       (rem_o),
  .dz_i        (dz_o),
  .tag_i       (tag_o),
  .busy_i      (busy_o)
);

`default_nettype wire

// ==== sim/divsqrt_tb.sv ====
// ------------------------------------------------
// Self-checking testbench for the divide/square-root top
// Directed, random, back-pressure and flush runs
// ------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module divsqrt_tb
  import divsqrt_pkg::*;
();

  // Upper bound on operations issued over all tests
  localparam int unsigned NUM_OPS     = 240;
  localparam longint      WATCHDOG_NS = NUM_OPS * 40 * 8;
  // Expected entry is result, remainder, dz and tag
  localparam int unsigned ENT_W       = 2 * DATA_W + 1 + TAG_W;

  logic              clk;
  logic              rst_n;
  logic              in_valid;
  logic              in_ready;
  logic [DATA_W-1:0] opa;
  logic [DATA_W-1:0] opb;
  logic              op;
  logic [TAG_W-1:0]  tag;
  logic              flush;
  logic              out_valid;
  logic              out_ready;
  logic [DATA_W-1:0] result;
  logic [DATA_W-1:0] rem;
  logic              dz;
  logic [TAG_W-1:0]  out_tag;
  logic              busy;

  // Scoreboard and bookkeeping
  logic [ENT_W-1:0]  sb[$];
  logic [ENT_W-1:0]  exp_ent;
  logic [15:0]       stim_lfsr;
  logic [15:0]       bp_lfsr;
  logic [15:0]       bp_bits;
  logic              bp_en;
  int                errors;
  int                in_count;
  int                checked;
  int                tag_seq;
  int                mark_checked;
  int                mark_errors;
  int                tests_failed;

  divsqrt_top uut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .opa_i       (opa),
    .opb_i       (opb),
    .op_i        (op),
    .tag_i       (tag),
    .flush_i     (flush),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .result_o    (result),
    .rem_o       (rem),
    .dz_o        (dz),
    .tag_o       (out_tag),
    .busy_o      (busy)
  );

  // 8 ns clock
  initial clk = 1'b0;
  always #4 clk = ~clk;

  // ------------------------------------------------
  // Random source and reference model
  // ------------------------------------------------
  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit, bits land LSB first from the right
  task automatic take_bits(inout logic [15:0] state, input int n, output logic [15:0] bits);
    bits = '0;
    for (int k = 0; k < n; k++) begin
      state = lfsr_step(state);
      bits  = {bits[14:0], state[0]};
    end
  endtask

  // Returns {quotient or root, remainder, dz}
  function automatic logic [2*DATA_W:0] ref_divsqrt(input logic o,
                                                    input logic [DATA_W-1:0] a,
                                                    input logic [DATA_W-1:0] b);
    logic [DATA_W-1:0] q;
    logic [DATA_W-1:0] r;
    logic              dzf;
    int unsigned       root;
    dzf = 1'b0;
    if (o == OP_SQRT) begin
      // Largest root whose square still fits under a
      root = 0;
      while ((root + 32'd1) * (root + 32'd1) <= 32'(a)) begin
        root = root + 32'd1;
      end
      q = DATA_W'(root);
      r = DATA_W'(32'(a) - root * root);
    end else if (b == '0) begin
      q   = '1;
      r   = a;
      dzf = 1'b1;
    end else begin
      q = a / b;
      r = a % b;
    end
    return {q, r, dzf};
  endfunction

  // ------------------------------------------------
  // Scoreboard and compare
  // ------------------------------------------------
  always @(posedge clk) begin
    if (flush) begin
      // Everything in flight is dropped by the DUT
      sb.delete();
    end else begin
      if (in_valid && in_ready) begin
        sb.push_back({ref_divsqrt(op, opa, opb), tag});
        in_count++;
      end
      if (out_valid && out_ready) begin
        if (sb.size() == 0) begin
          $display("%0d ns: result with tag %h came out with no operation pending",
                   $time, out_tag);
          errors++;
        end else begin
          exp_ent = sb.pop_front();
          checked++;
          if (result !== exp_ent[ENT_W-1 -: DATA_W]) begin
            $display("[ERROR] %0d ns: result_o = %h, expected %h",
                     $time, result, exp_ent[ENT_W-1 -: DATA_W]);
            errors++;
          end
          if (rem !== exp_ent[TAG_W+DATA_W -: DATA_W]) begin
            $display("[ERROR] %0d ns: rem_o = %h, expected %h",
                     $time, rem, exp_ent[TAG_W+DATA_W -: DATA_W]);
            errors++;
          end
          if (dz !== exp_ent[TAG_W]) begin
            $display("[ERROR] %0d ns: dz_o = %b, expected %b", $time, dz, exp_ent[TAG_W]);
            errors++;
          end
          if (out_tag !== exp_ent[TAG_W-1:0]) begin
            $display("[ERROR] %0d ns: tag_o = %h, expected %h",
                     $time, out_tag, exp_ent[TAG_W-1:0]);
            errors++;
          end
        end
      end
    end
  end

  // Downstream ready, random stalls only while enabled
  always @(posedge clk) begin
    if (bp_en) begin
      take_bits(bp_lfsr, 2, bp_bits);
      out_ready <= (bp_bits[1:0] != 2'b00);
    end else begin
      out_ready <= 1'b1;
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

  // ------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------
  // Holds the item until an edge sees in_ready_o high
  task automatic send_op(input logic o, input logic [DATA_W-1:0] a,
                         input logic [DATA_W-1:0] b);
    in_valid <= 1'b1;
    op       <= o;
    opa      <= a;
    opb      <= b;
    tag      <= TAG_W'(tag_seq);
    tag_seq++;
    @(posedge clk);
    while (!in_ready) begin
      @(posedge clk);
    end
    in_valid <= 1'b0;
  endtask

  // One operation at a time, latency checked when exp_lat is nonzero
  task automatic run_one(input logic o, input logic [DATA_W-1:0] a,
                         input logic [DATA_W-1:0] b, input int exp_lat);
    int lat;
    send_op(o, a, b);
    lat = 0;
    while (!out_valid) begin
      @(posedge clk);
      lat++;
    end
    // out_valid_o shows up one edge after the edge that raised it
    if (exp_lat > 0 && lat - 1 != exp_lat) begin
      $display("[ERROR] %0d ns: out_valid_o latency = %0d cycles, expected %0d",
               $time, lat - 1, exp_lat);
      errors++;
    end
  endtask

  // Waits for the scoreboard to empty, then prints the test line
  task automatic end_test(input int num, input string name);
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (sb.size() != 0 && waited < 4000);
    if (sb.size() != 0) begin
      $display("%0d ns: %0d operations never produced a result", $time, sb.size());
      errors++;
      sb.delete();
    end
    if (errors != mark_errors) begin
      tests_failed++;
    end
    $display("test %0d %s: %0d results checked, %0d mismatches",
             num, name, checked - mark_checked, errors - mark_errors);
    mark_checked = checked;
    mark_errors  = errors;
    @(posedge clk);
  endtask

  // ------------------------------------------------
  // Test sequence
  // ------------------------------------------------
  initial begin : stimulus
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] bits;
    logic        o;
    int          i;
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    opa          = '0;
    opb          = '0;
    op           = OP_DIV;
    tag          = '0;
    flush        = 1'b0;
    out_ready    = 1'b0;
    bp_en        = 1'b0;
    stim_lfsr    = 16'd57;
    bp_lfsr      = 16'd57;
    errors       = 0;
    in_count     = 0;
    checked      = 0;
    tag_seq      = 0;
    mark_checked = 0;
    mark_errors  = 0;
    tests_failed = 0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Test 1, idle state after reset, then directed divides
    if (in_ready !== 1'b1) begin
      $display("[ERROR] %0d ns: in_ready_o = %b, expected 1", $time, in_ready);
      errors++;
    end
    if (out_valid !== 1'b0) begin
      $display("[ERROR] %0d ns: out_valid_o = %b, expected 0", $time, out_valid);
      errors++;
    end
    if (busy !== 1'b0) begin
      $display("[ERROR] %0d ns: busy_o = %b, expected 0", $time, busy);
      errors++;
    end
    if (dz !== 1'b0) begin
      $display("[ERROR] %0d ns: dz_o = %b, expected 0", $time, dz);
      errors++;
    end
    run_one(OP_DIV, 16'd1000, 16'd7, 18);
    run_one(OP_DIV, 16'd5, 16'd9, 0);
    run_one(OP_DIV, 16'd12345, 16'd1, 0);
    run_one(OP_DIV, 16'hFFFF, 16'd255, 0);
    run_one(OP_DIV, 16'd40000, 16'd40000, 0);
    run_one(OP_DIV, 16'd0, 16'd3, 0);
    end_test(1, "directed divide");

    // Test 2, zero divisor
    run_one(OP_DIV, 16'd1234, 16'd0, 0);
    run_one(OP_DIV, 16'd0, 16'd0, 0);
    run_one(OP_DIV, 16'hFFFF, 16'd0, 0);
    end_test(2, "divide by zero");

    // Test 3, roots at the edges, perfect squares and random values
    run_one(OP_SQRT, 16'd0, 16'd0, 10);
    run_one(OP_SQRT, 16'd1, 16'd0, 0);
    run_one(OP_SQRT, 16'hFFFF, 16'd0, 0);
    run_one(OP_SQRT, 16'd4, 16'd0, 0);
    run_one(OP_SQRT, 16'd144, 16'd0, 0);
    run_one(OP_SQRT, 16'd10000, 16'd0, 0);
    run_one(OP_SQRT, 16'd65025, 16'd0, 0);
    for (i = 0; i < 6; i++) begin
      take_bits(stim_lfsr, 16, a);
      run_one(OP_SQRT, a, 16'd0, 0);
    end
    end_test(3, "square root");

    // Test 4, random mix with idle gaps and output stalls
    bp_en <= 1'b1;
    for (i = 0; i < 200; i++) begin
      take_bits(stim_lfsr, 2, bits);
      repeat (bits[1:0]) @(posedge clk);
      take_bits(stim_lfsr, 1, bits);
      o = bits[0];
      take_bits(stim_lfsr, 16, a);
      take_bits(stim_lfsr, 1, bits);
      // Narrow divisors half the time for larger quotients
      if (bits[0]) begin
        take_bits(stim_lfsr, 8, b);
      end else begin
        take_bits(stim_lfsr, 16, b);
      end
      send_op(o, a, b);
    end
    bp_en <= 1'b0;
    end_test(4, "random with back-pressure");

    // Test 5, one op in the core and one in the input slice, then flush
    send_op(OP_DIV, 16'd50000, 16'd3);
    send_op(OP_SQRT, 16'd9999, 16'd0);
    repeat (3) @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    @(posedge clk);
    if (busy !== 1'b0) begin
      $display("[ERROR] %0d ns: busy_o = %b, expected 0", $time, busy);
      errors++;
    end
    if (out_valid !== 1'b0) begin
      $display("[ERROR] %0d ns: out_valid_o = %b, expected 0", $time, out_valid);
      errors++;
    end
    // Quiet period, any result now is a leak from the flushed ops
    repeat (30) @(posedge clk);
    run_one(OP_DIV, 16'd777, 16'd13, 0);
    run_one(OP_SQRT, 16'd50, 16'd0, 0);
    run_one(OP_DIV, 16'd9, 16'd0, 0);
    run_one(OP_SQRT, 16'd256, 16'd0, 0);
    end_test(5, "flush");

    @(negedge clk);
    $display("summary: %0d ops issued, %0d results checked, %0d tests failed, %0d errors",
             in_count, checked, tests_failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== divsqrt_lite.f ====
design/divsqrt_pkg.sv
design/divsqrt_pipe_reg.sv
design/divsqrt_ctrl.sv
design/divsqrt_iter_unit.sv
design/divsqrt_top.sv
sim/divsqrt_chk.sv
sim/divsqrt_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the divsqrt testbench with Verilator

LOG=sim.log
BIN=divsqrt_sim

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module divsqrt_tb -f divsqrt_lite.f -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
